//--- design/rv_pkg.sv
package rv_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // Major opcodes and the zero value of an empty slot
  typedef enum logic [6:0] {
    OP_NOP    = 7'b0000000,
    OP_LUI    = 7'b0110111,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_R_IMM  = 7'b0010011,
    OP_R_TYPE = 7'b0110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS  // Passes operand b through for LUI
  } alu_op_e;

  // funct3 of the ALU groups
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // Only the word size is kept for LW and SW
  localparam logic [2:0] F3_WORD = 3'b010;

  // funct7 selects SUB and SRA/SRAI
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

endpackage

//--- design/rv_ex_if.sv
`timescale 1ns/1ps

interface rv_ex_if import rv_pkg::*; ();

  logic      valid;      // Slot holds a real instruction
  logic      reg_write;
  logic      mem_read;
  logic      mem_write;
  logic      use_imm;    // Operand b is imm instead of rs2
  alu_op_e   alu_op;
  reg_addr_t rd;
  reg_addr_t rs1;
  reg_addr_t rs2;
  word_t     rs1_data;
  word_t     rs2_data;
  word_t     imm;

  modport decode (
    output valid, reg_write, mem_read, mem_write, use_imm, alu_op,
    output rd, rs1, rs2, rs1_data, rs2_data, imm
  );

  modport execute (
    input valid, reg_write, mem_read, mem_write, use_imm, alu_op,
    input rd, rs1, rs2, rs1_data, rs2_data, imm
  );

endinterface

//--- design/rv_mem_if.sv
`timescale 1ns/1ps

interface rv_mem_if import rv_pkg::*; ();

  // Already qualified by the execute slot valid
  logic      reg_write;
  logic      mem_read;
  reg_addr_t rd;
  word_t     alu_result;  // Load address for loads

  modport execute (
    output reg_write, mem_read, rd, alu_result
  );

  modport writeback (
    input reg_write, mem_read, rd, alu_result
  );

endinterface

//--- design/reg_file.sv
`timescale 1ns/1ps

module reg_file import rv_pkg::*; (
  input  logic      sys_clk,
  input  reg_addr_t rs1_addr,
  input  reg_addr_t rs2_addr,
  output word_t     rs1_rdata,
  output word_t     rs2_rdata,
  input  logic      wb_en,
  input  reg_addr_t wb_rd,
  input  word_t     wb_data
);

  word_t regs [32];

  // Entry 0 is never written
  always_ff @(posedge sys_clk) begin
    if (wb_en && (wb_rd != '0)) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // Same-cycle write is visible to decode
  assign rs1_rdata = (rs1_addr == '0)                  ? '0      :
                     (wb_en && (wb_rd == rs1_addr))    ? wb_data :
                                                         regs[rs1_addr];

  assign rs2_rdata = (rs2_addr == '0)                  ? '0      :
                     (wb_en && (wb_rd == rs2_addr))    ? wb_data :
                                                         regs[rs2_addr];

endmodule

//--- design/fetch_decode.sv
`timescale 1ns/1ps

module fetch_decode import rv_pkg::*; #(
  parameter word_t RESET_PC = 32'h0
) (
  input  logic      sys_clk,
  input  logic      reset_n,
  output word_t     imem_addr,
  input  word_t     imem_read_data,
  output reg_addr_t rs1_addr,
  output reg_addr_t rs2_addr,
  input  word_t     rs1_rdata,
  input  word_t     rs2_rdata,
  rv_ex_if.decode   ex
);

  logic       fetch_valid;  // imem_read_data carries a fetched word
  logic       replay;       // Decode the held copy this cycle
  logic       stall;
  word_t      held_instr;
  word_t      instr;
  opcode_e    opcode;
  reg_addr_t  rd;
  logic       dec_valid;
  logic       dec_reg_write;
  logic       dec_mem_read;
  logic       dec_mem_write;
  logic       dec_use_imm;
  alu_op_e    dec_alu_op;
  word_t      dec_imm;

  function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic [6:0] f7,
                                         input logic is_imm);
    alu_op_e op;
    op = ALU_ADD;
    case (f3)
      F3_ADD_SUB: op = ((f7 == F7_ALT) && !is_imm) ? ALU_SUB : ALU_ADD;  // No SUBI
      F3_SLL:     op = ALU_SLL;
      F3_SLT:     op = ALU_SLT;
      F3_SLTU:    op = ALU_SLTU;
      F3_XOR:     op = ALU_XOR;
      F3_SRL_SRA: op = (f7 == F7_ALT) ? ALU_SRA : ALU_SRL;
      F3_OR:      op = ALU_OR;
      F3_AND:     op = ALU_AND;
    endcase
    return op;
  endfunction

  assign instr    = replay ? held_instr : imem_read_data;
  assign opcode   = opcode_e'(instr[6:0]);
  assign rs1_addr = instr[19:15];
  assign rs2_addr = instr[24:20];
  assign rd       = instr[11:7];

  always_comb begin
    dec_valid     = fetch_valid;
    dec_reg_write = 1'b0;
    dec_mem_read  = 1'b0;
    dec_mem_write = 1'b0;
    dec_use_imm   = 1'b1;
    dec_alu_op    = ALU_ADD;
    dec_imm       = {{20{instr[31]}}, instr[31:20]};  // I-type by default
    case (opcode)
      OP_LUI: begin
        dec_reg_write = 1'b1;
        dec_alu_op    = ALU_PASS;
        dec_imm       = {instr[31:12], 12'b0};
      end
      OP_LOAD: begin
        dec_valid     = fetch_valid && (instr[14:12] == F3_WORD);
        dec_reg_write = 1'b1;
        dec_mem_read  = 1'b1;
      end
      OP_STORE: begin
        dec_valid     = fetch_valid && (instr[14:12] == F3_WORD);
        dec_mem_write = 1'b1;
        dec_imm       = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      end
      OP_R_IMM: begin
        dec_reg_write = 1'b1;
        dec_alu_op    = alu_decode(instr[14:12], instr[31:25], 1'b1);
      end
      OP_R_TYPE: begin
        dec_reg_write = 1'b1;
        dec_use_imm   = 1'b0;
        dec_alu_op    = alu_decode(instr[14:12], instr[31:25], 1'b0);
      end
      OP_NOP:  dec_valid = 1'b0;  // Empty slot
      default: dec_valid = 1'b0;  // Unknown opcode turns into a bubble
    endcase
  end

  // Load in execute feeds this instruction
  assign stall = dec_valid && ex.valid && ex.mem_read && (ex.rd != '0) &&
                 ((ex.rd == rs1_addr) || (ex.rd == rs2_addr));

  always_ff @(posedge sys_clk) begin
    if (!reset_n) begin
      imem_addr   <= RESET_PC;
      fetch_valid <= 1'b0;
      replay      <= 1'b0;
    end else begin
      fetch_valid <= 1'b1;
      replay      <= stall;
      if (!stall) begin
        imem_addr <= imem_addr + 32'd4;
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (stall) begin
      held_instr <= instr;
    end
  end

  // Decode to execute register
  always_ff @(posedge sys_clk) begin
    if (!reset_n) begin
      ex.valid     <= 1'b0;
      ex.reg_write <= 1'b0;
      ex.mem_read  <= 1'b0;
      ex.mem_write <= 1'b0;
    end else begin
      ex.valid     <= dec_valid && !stall;  // Bubble while stalled
      ex.reg_write <= dec_reg_write;
      ex.mem_read  <= dec_mem_read;
      ex.mem_write <= dec_mem_write;
    end
  end

  always_ff @(posedge sys_clk) begin
    ex.use_imm  <= dec_use_imm;
    ex.alu_op   <= dec_alu_op;
    ex.rd       <= rd;
    ex.rs1      <= rs1_addr;
    ex.rs2      <= rs2_addr;
    ex.rs1_data <= rs1_rdata;
    ex.rs2_data <= rs2_rdata;
    ex.imm      <= dec_imm;
  end

endmodule

//--- design/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import rv_pkg::*; (
  input  logic      sys_clk,
  input  logic      reset_n,
  rv_ex_if.execute  ex,
  rv_mem_if.execute mem,
  input  logic      wb_en,
  input  reg_addr_t wb_rd,
  input  word_t     wb_data,
  output logic      dmem_read_cmd_valid,
  output logic      dmem_write_cmd_valid,
  output word_t     dmem_addr,
  output word_t     dmem_write_data
);

  logic  mem_fwd_ok;
  logic  wb_fwd_ok;
  word_t rs1_val;
  word_t rs2_val;
  word_t op_a;
  word_t op_b;
  word_t alu_result;

  // No load data yet in the memory slot
  assign mem_fwd_ok = mem.reg_write && !mem.mem_read && (mem.rd != '0);
  assign wb_fwd_ok  = wb_en && (wb_rd != '0);

  // Newest producer wins
  always_comb begin
    if (mem_fwd_ok && (mem.rd == ex.rs1)) begin
      rs1_val = mem.alu_result;
    end else if (wb_fwd_ok && (wb_rd == ex.rs1)) begin
      rs1_val = wb_data;
    end else begin
      rs1_val = ex.rs1_data;
    end
  end

  always_comb begin
    if (mem_fwd_ok && (mem.rd == ex.rs2)) begin
      rs2_val = mem.alu_result;
    end else if (wb_fwd_ok && (wb_rd == ex.rs2)) begin
      rs2_val = wb_data;
    end else begin
      rs2_val = ex.rs2_data;
    end
  end

  assign op_a = rs1_val;
  assign op_b = ex.use_imm ? ex.imm : rs2_val;

  always_comb begin
    case (ex.alu_op)
      ALU_ADD:  alu_result = op_a + op_b;  // Also the load/store address
      ALU_SUB:  alu_result = op_a - op_b;
      ALU_SLL:  alu_result = op_a << op_b[4:0];
      ALU_SLT:  alu_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: alu_result = {{(XLEN-1){1'b0}}, op_a < op_b};
      ALU_XOR:  alu_result = op_a ^ op_b;
      ALU_SRL:  alu_result = op_a >> op_b[4:0];
      ALU_SRA:  alu_result = word_t'($signed(op_a) >>> op_b[4:0]);
      ALU_OR:   alu_result = op_a | op_b;
      ALU_AND:  alu_result = op_a & op_b;
      ALU_PASS: alu_result = op_b;
      default:  alu_result = '0;
    endcase
  end

  // Data memory command in the execute cycle
  assign dmem_read_cmd_valid  = ex.valid && ex.mem_read;
  assign dmem_write_cmd_valid = ex.valid && ex.mem_write;
  assign dmem_addr            = alu_result;
  assign dmem_write_data      = rs2_val;  // Store data after forwarding

  // Execute to memory register
  always_ff @(posedge sys_clk) begin
    if (!reset_n) begin
      mem.reg_write <= 1'b0;
      mem.mem_read  <= 1'b0;
    end else begin
      mem.reg_write <= ex.valid && ex.reg_write;
      mem.mem_read  <= ex.valid && ex.mem_read;
    end
  end

  always_ff @(posedge sys_clk) begin
    mem.rd         <= ex.rd;
    mem.alu_result <= alu_result;
  end

endmodule

//--- design/memory_writeback.sv
`timescale 1ns/1ps

module memory_writeback import rv_pkg::*; (
  input  logic        sys_clk,
  input  logic        reset_n,
  rv_mem_if.writeback mem,
  input  word_t       dmem_read_data,
  output logic        wb_en,
  output reg_addr_t   wb_rd,
  output word_t       wb_data
);

  logic  wb_is_load;
  word_t load_data;
  word_t alu_result;

  always_ff @(posedge sys_clk) begin
    if (!reset_n) begin
      wb_en      <= 1'b0;
      wb_is_load <= 1'b0;
    end else begin
      wb_en      <= mem.reg_write;
      wb_is_load <= mem.mem_read;
    end
  end

  always_ff @(posedge sys_clk) begin
    wb_rd      <= mem.rd;
    alu_result <= mem.alu_result;
    load_data  <= dmem_read_data;  // Valid one cycle after the read command
  end

  // Write-back bus and second forwarding source
  assign wb_data = wb_is_load ? load_data : alu_result;

endmodule

//--- design/riscv_core.sv
`timescale 1ns/1ps

module riscv_core import rv_pkg::*; #(
  parameter word_t RESET_PC = 32'h0
) (
  input  logic  sys_clk,
  input  logic  reset_n,
  output word_t imem_addr,
  input  word_t imem_read_data,
  output logic  dmem_read_cmd_valid,
  output logic  dmem_write_cmd_valid,
  output word_t dmem_addr,
  output word_t dmem_write_data,
  input  word_t dmem_read_data
);

  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  word_t     rs1_rdata;
  word_t     rs2_rdata;
  logic      wb_en;
  reg_addr_t wb_rd;
  word_t     wb_data;

  rv_ex_if  ex_slot ();
  rv_mem_if mem_slot ();

  fetch_decode #(
    .RESET_PC (RESET_PC)
  ) i_fetch_decode (
    .sys_clk        (sys_clk),
    .reset_n        (reset_n),
    .imem_addr      (imem_addr),
    .imem_read_data (imem_read_data),
    .rs1_addr       (rs1_addr),
    .rs2_addr       (rs2_addr),
    .rs1_rdata      (rs1_rdata),
    .rs2_rdata      (rs2_rdata),
    .ex             (ex_slot.decode)
  );

  reg_file i_reg_file (
    .sys_clk   (sys_clk),
    .rs1_addr  (rs1_addr),
    .rs2_addr  (rs2_addr),
    .rs1_rdata (rs1_rdata),
    .rs2_rdata (rs2_rdata),
    .wb_en     (wb_en),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data)
  );

  execute_stage i_execute_stage (
    .sys_clk              (sys_clk),
    .reset_n              (reset_n),
    .ex                   (ex_slot.execute),
    .mem                  (mem_slot.execute),
    .wb_en                (wb_en),
    .wb_rd                (wb_rd),
    .wb_data              (wb_data),
    .dmem_read_cmd_valid  (dmem_read_cmd_valid),
    .dmem_write_cmd_valid (dmem_write_cmd_valid),
    .dmem_addr            (dmem_addr),
    .dmem_write_data      (dmem_write_data)
  );

  memory_writeback i_memory_writeback (
    .sys_clk        (sys_clk),
    .reset_n        (reset_n),
    .mem            (mem_slot.writeback),
    .dmem_read_data (dmem_read_data),
    .wb_en          (wb_en),
    .wb_rd          (wb_rd),
    .wb_data        (wb_data)
  );

endmodule

//--- tests/riscv_core_assertions.sv
`timescale 1ns/1ps

module riscv_core_tests_assertions import rv_pkg::*; #(
  parameter word_t RESET_PC = 32'h0
) (
  input logic  sys_clk,
  input logic  reset_n,
  input word_t imem_addr,
  input logic  stall,
  input logic  slot_valid,  // Execute slot holds a real instruction
  input logic  read_cmd,
  input logic  write_cmd
);

  // The stalled instruction leaves an empty execute slot behind
  assert property (@(posedge sys_clk) disable iff (!reset_n)
    stall |=> (!slot_valid && !read_cmd && !write_cmd))
    else $error("load-use stall did not leave an empty execute slot");

  assert property (@(posedge sys_clk) disable iff (!reset_n) !(read_cmd && write_cmd))
    else $error("read and write commands high in the same cycle");

  // Fetch address frozen for the repeated decode
  assert property (@(posedge sys_clk) disable iff (!reset_n) stall |=> $stable(imem_addr))
    else $error("fetch address moved during a load-use stall");

  assert property (@(posedge sys_clk) !reset_n |=> (imem_addr == RESET_PC))
    else $error("fetch address is not the reset address after reset");

endmodule

bind riscv_core riscv_core_tests_assertions #(
  .RESET_PC (RESET_PC)
) i_pipeline_checks (
  .sys_clk    (sys_clk),
  .reset_n    (reset_n),
  .imem_addr  (imem_addr),
  .stall      (i_fetch_decode.stall),
  .slot_valid (ex_slot.valid),
  .read_cmd   (dmem_read_cmd_valid),
  .write_cmd  (dmem_write_cmd_valid)
);

//--- tests/riscv_core_tb.sv
`timescale 1ns/1ps

module riscv_core_tb import rv_pkg::*; ();

  localparam word_t RESET_PC = 32'h0000_0080;
  localparam int    TIMEOUT  = 200;  // Cycles allowed per program

  logic   sys_clk;
  logic   reset_n;
  word_t  imem_addr;
  word_t  imem_read_data;
  logic   dmem_read_cmd_valid;
  logic   dmem_write_cmd_valid;
  word_t  dmem_addr;
  word_t  dmem_write_data;
  word_t  dmem_read_data;

  word_t  imem [256];
  word_t  dmem [word_t];
  word_t  fetch_addr;
  word_t  read_addr;
  word_t  prog [$];
  word_t  exp_addr [$];
  word_t  exp_data [$];
  word_t  got_addr [$];
  word_t  got_data [$];
  integer seed;
  int     mismatches;
  int     timeouts;

  riscv_core #(
    .RESET_PC (RESET_PC)
  ) i_dut (
    .sys_clk              (sys_clk),
    .reset_n              (reset_n),
    .imem_addr            (imem_addr),
    .imem_read_data       (imem_read_data),
    .dmem_read_cmd_valid  (dmem_read_cmd_valid),
    .dmem_write_cmd_valid (dmem_write_cmd_valid),
    .dmem_addr            (dmem_addr),
    .dmem_write_data      (dmem_write_data),
    .dmem_read_data       (dmem_read_data)
  );

  initial begin
    sys_clk = 1'b0;
    forever #5 sys_clk = ~sys_clk;
  end

  // Both memories answer one cycle after the request
  always @(negedge sys_clk) begin
    imem_read_data = imem[fetch_addr[9:2]];
    fetch_addr     = imem_addr;
    dmem_read_data = dmem.exists(read_addr) ? dmem[read_addr] : ~read_addr;
    if (dmem_write_cmd_valid === 1'b1) begin
      dmem[dmem_addr] = dmem_write_data;
      got_addr.push_back(dmem_addr);  // Store log in arrival order
      got_data.push_back(dmem_write_data);
    end
    if (dmem_read_cmd_valid === 1'b1) begin
      read_addr = dmem_addr;
    end
  end

  function automatic word_t sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  // RV32I result of one ALU group with alt selecting SUB or SRA
  function automatic word_t alu_model(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
    case (f3)
      F3_ADD_SUB: return alt ? a - b : a + b;
      F3_SLL:     return a << b[4:0];
      F3_SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      F3_SLTU:    return (a < b) ? 32'd1 : 32'd0;
      F3_XOR:     return a ^ b;
      F3_SRL_SRA: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      F3_OR:      return a | b;
      default:    return a & b;
    endcase
  endfunction

  function automatic word_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                   input reg_addr_t rd, input reg_addr_t rs1,
                                   input reg_addr_t rs2);
    return {f7, rs2, rs1, f3, rd, OP_R_TYPE};
  endfunction

  function automatic word_t i_type(input logic [2:0] f3, input reg_addr_t rd,
                                   input reg_addr_t rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, OP_R_IMM};
  endfunction

  function automatic word_t load_word(input reg_addr_t rd, input reg_addr_t rs1,
                                      input logic [11:0] imm);
    return {imm, rs1, F3_WORD, rd, OP_LOAD};
  endfunction

  function automatic word_t store_word(input reg_addr_t rs2, input reg_addr_t rs1,
                                       input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OP_STORE};
  endfunction

  function automatic word_t upper_imm(input reg_addr_t rd, input logic [19:0] imm);
    return {imm, rd, OP_LUI};
  endfunction

  // LUI plus ADDI with the upper part rounded for the signed low half
  task automatic load_const(input reg_addr_t rd, input word_t value);
    word_t upper;
    upper = value + 32'h800;
    prog.push_back(upper_imm(rd, upper[31:12]));
    prog.push_back(i_type(F3_ADD_SUB, rd, rd, value[11:0]));
  endtask

  task automatic store_and_expect(input reg_addr_t rs, input word_t value);
    word_t addr;
    addr = 32'h400 + 4 * exp_addr.size();  // Stores go to consecutive words
    prog.push_back(store_word(rs, 5'd0, addr[11:0]));
    exp_addr.push_back(addr);
    exp_data.push_back(value);
  endtask

  task automatic compare_word(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      $display("mismatch %s expected %h actual %h", name, expected, actual);
      mismatches++;
    end
  endtask

  task automatic compare_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("mismatch %s expected %b actual %b", name, expected, actual);
      mismatches++;
    end
  endtask

  task automatic execute_program(input string name);
    int cycles;
    int i;
    @(negedge sys_clk);
    reset_n = 1'b0;
    for (i = 0; i < 256; i++) begin
      imem[i] = '0;
    end
    for (i = 0; i < prog.size(); i++) begin
      imem[RESET_PC[9:2] + i] = prog[i];
    end
    dmem.delete();
    repeat (3) @(negedge sys_clk);
    got_addr.delete();
    got_data.delete();
    reset_n = 1'b1;
    cycles  = 0;
    while ((got_addr.size() < exp_addr.size()) && (cycles < TIMEOUT)) begin
      @(negedge sys_clk);
      cycles++;
    end
    if (got_addr.size() < exp_addr.size()) begin
      $display("Test %s hung: %0d of %0d stores seen before the timeout",
               name, got_addr.size(), exp_addr.size());
      timeouts++;
    end else begin
      for (i = 0; i < exp_addr.size(); i++) begin
        compare_word(name, exp_addr[i], got_addr[i]);
        compare_word(name, exp_data[i], got_data[i]);
      end
    end
    prog.delete();
    exp_addr.delete();
    exp_data.delete();
  endtask

  task automatic reset_values();
    @(negedge sys_clk);
    reset_n = 1'b0;
    repeat (3) @(negedge sys_clk);
    compare_word("reset_values", RESET_PC, imem_addr);
    compare_flag("reset_values", 1'b0, dmem_read_cmd_valid);
    compare_flag("reset_values", 1'b0, dmem_write_cmd_valid);
    reset_n = 1'b1;
  endtask

  task automatic alu_ops();
    word_t      a;
    word_t      b;
    word_t      imm;
    logic [2:0] f3;
    logic [11:0] imm12;
    int         f;
    a = $random(seed);
    b = $random(seed);
    load_const(5'd1, a);
    load_const(5'd2, b);
    for (f = 0; f < 8; f++) begin
      f3 = 3'(f);
      prog.push_back(r_type(F7_BASE, f3, 5'd3, 5'd1, 5'd2));
      store_and_expect(5'd3, alu_model(f3, 1'b0, a, b));
      if ((f3 == F3_ADD_SUB) || (f3 == F3_SRL_SRA)) begin
        prog.push_back(r_type(F7_ALT, f3, 5'd3, 5'd1, 5'd2));
        store_and_expect(5'd3, alu_model(f3, 1'b1, a, b));
      end
      imm   = $random(seed);
      imm12 = ((f3 == F3_SLL) || (f3 == F3_SRL_SRA)) ? {F7_BASE, imm[4:0]} : imm[11:0];
      prog.push_back(i_type(f3, 5'd3, 5'd1, imm12));
      store_and_expect(5'd3, alu_model(f3, 1'b0, a, sext12(imm12)));
      if (f3 == F3_SRL_SRA) begin
        imm12 = {F7_ALT, imm[4:0]};  // SRAI
        prog.push_back(i_type(f3, 5'd3, 5'd1, imm12));
        store_and_expect(5'd3, alu_model(f3, 1'b1, a, sext12(imm12)));
      end
    end
    execute_program("alu_ops");
  endtask

  // Chain with producers one, two and three slots back
  task automatic forwarding_chain();
    word_t a;
    word_t imm;
    word_t v6;
    word_t v7;
    word_t v8;
    a   = $random(seed);
    imm = $random(seed);
    v6  = alu_model(F3_ADD_SUB, 1'b0, a, sext12(imm[11:0]));
    v7  = alu_model(F3_ADD_SUB, 1'b0, v6, a);
    v8  = alu_model(F3_ADD_SUB, 1'b1, v7, v6);
    load_const(5'd5, a);
    prog.push_back(i_type(F3_ADD_SUB, 5'd6, 5'd5, imm[11:0]));
    prog.push_back(r_type(F7_BASE, F3_ADD_SUB, 5'd7, 5'd6, 5'd5));
    prog.push_back(r_type(F7_ALT, F3_ADD_SUB, 5'd8, 5'd7, 5'd6));
    store_and_expect(5'd8, v8);
    prog.push_back(r_type(F7_BASE, F3_XOR, 5'd9, 5'd8, 5'd7));
    store_and_expect(5'd9, alu_model(F3_XOR, 1'b0, v8, v7));
    store_and_expect(5'd6, v6);
    store_and_expect(5'd7, v7);
    execute_program("forwarding_chain");
  endtask

  task automatic load_use_stall();
    word_t v;
    v = $random(seed);
    load_const(5'd10, v);
    store_and_expect(5'd10, v);  // Lands at 0x400
    prog.push_back(load_word(5'd11, 5'd0, 12'h400));
    prog.push_back(r_type(F7_BASE, F3_ADD_SUB, 5'd12, 5'd11, 5'd10));
    store_and_expect(5'd12, v + v);
    prog.push_back(load_word(5'd13, 5'd0, 12'h400));
    store_and_expect(5'd13, v);  // Store data right behind the load
    execute_program("load_use_stall");
  endtask

  task automatic x0_and_lui();
    word_t r;
    word_t up;
    r  = $random(seed);
    up = $random(seed);
    prog.push_back(i_type(F3_ADD_SUB, 5'd0, 5'd0, r[11:0]));
    prog.push_back(upper_imm(5'd0, r[31:12]));
    store_and_expect(5'd0, 32'h0);
    prog.push_back(upper_imm(5'd16, up[19:0]));
    store_and_expect(5'd16, {up[19:0], 12'h000});
    execute_program("x0_and_lui");
  endtask

  initial begin
    seed            = 23;
    reset_n         = 1'b0;
    imem_read_data  = '0;
    dmem_read_data  = '0;
    fetch_addr      = RESET_PC;
    read_addr       = '0;
    mismatches      = 0;
    timeouts        = 0;
    reset_values();
    alu_ops();
    forwarding_chain();
    load_use_stall();
    x0_and_lui();
    $display("Errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if ((mismatches == 0) && (timeouts == 0)) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- verilog.f
design/rv_pkg.sv
design/rv_ex_if.sv
design/rv_mem_if.sv
design/reg_file.sv
design/fetch_decode.sv
design/execute_stage.sv
design/memory_writeback.sv
design/riscv_core.sv
tests/riscv_core_assertions.sv
tests/riscv_core_tb.sv

//--- Bender.yml
package:
  name: riscv_core

sources:
  - files:
      - design/rv_pkg.sv
      - design/rv_ex_if.sv
      - design/rv_mem_if.sv
      - design/reg_file.sv
      - design/fetch_decode.sv
      - design/execute_stage.sv
      - design/memory_writeback.sv
      - design/riscv_core.sv
  - target: test
    files:
      - tests/riscv_core_assertions.sv
      - tests/riscv_core_tb.sv
